//--- files.f
+incdir+source
source/plru_tree_pkg.sv
source/plru_ctrl_pkg.sv
source/plru_bit_ram.sv
source/plru_hit_update.sv
source/plru_victim_select.sv
source/plru_ctrl.sv
source/plru_top.sv
bench/plru_tb.sv

//--- run.sh
#!/bin/sh
# Compile the PLRU design and testbench with Verilator, then run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module plru_tb \
    -f files.f \
    -o plru_sim

# The simulation may stop early, its log is still searched below
./obj_dir/plru_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

//--- bench/plru_tb.sv
////////////////////////////////////////
// PLRU testbench
// Table-driven hits and evictions checked
// against a tree PLRU reference model
////////////////////////////////////////

`timescale 1ns/1ps

`include "plru_defs.svh"

module plru_tb;

    localparam int NW              = `PLRU_NUM_WAYS;
    localparam int TW              = `PLRU_TREE_W;
    localparam int IW              = `PLRU_INDEX_W;
    localparam int LINES           = `PLRU_NUM_LINES;
    localparam int ROWS            = NW + 32;
    localparam int RESET_CYCLES    = 5;
    localparam int DONE_LIMIT      = 6;
    localparam int WATCHDOG_CYCLES = ROWS * 10 + RESET_CYCLES;
    localparam logic ROW_HIT       = 1'b0;
    localparam logic ROW_EVICT     = 1'b1;
    localparam logic [NW-1:0] WAY_ONE  = 1;
    localparam logic [NW-1:0] LOW_HALF = (WAY_ONE << (NW / 2)) - WAY_ONE;
    localparam logic [NW-1:0] UP_HALF  = LOW_HALF << (NW / 2);
    localparam logic [NW-1:0] ODD_WAYS = {NW / 2{2'b10}};

    logic          clk = 1'b0;
    logic          rst_n;
    logic          hit;
    logic          evict;
    logic [NW-1:0] hit_way;
    logic [IW-1:0] line_idx;
    logic [NW-1:0] lock;
    logic [NW-1:0] dirty;
    logic          busy;
    logic          hit_done;
    logic          victim_valid;
    logic [NW-1:0] victim_way;
    logic          evict_dirty;

    // Stimulus table with expected columns filled by the model
    logic          op_tab        [ROWS];
    logic [IW-1:0] line_tab      [ROWS];
    logic [NW-1:0] mask_tab      [ROWS];
    logic [NW-1:0] dirty_tab     [ROWS];
    int            exp_way_tab   [ROWS];
    logic          exp_dirty_tab [ROWS];
    logic [TW-1:0] model_mem     [LINES];
    int            recent_hit    [LINES];
    logic [NW-1:0] seen_first;
    int            n_rows;
    int            errors;
    int            checks;
    integer        seed;

    always #2 clk = ~clk;

    plru_top u_plru_top (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .hit_i          (hit),
        .evict_i        (evict),
        .hit_way_i      (hit_way),
        .line_idx_i     (line_idx),
        .lock_i         (lock),
        .dirty_i        (dirty),
        .busy_o         (busy),
        .hit_done_o     (hit_done),
        .victim_valid_o (victim_valid),
        .victim_way_o   (victim_way),
        .evict_dirty_o  (evict_dirty)
    );

    initial begin
        #(WATCHDOG_CYCLES * 4);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic has_free(input logic [NW-1:0] lk, input int first, input int count);
        logic found;
        found = 1'b0;
        for (int w = first; w < first + count; w++) begin
            if (!lk[w]) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    function automatic int way_index(input logic [NW-1:0] onehot);
        int idx;
        idx = -1;
        for (int w = 0; w < NW; w++) begin
            if (onehot[w]) begin
                idx = w;
            end
        end
        return idx;
    endfunction

    // Victim walk takes the opposite half at each node unless it is fully locked
    task automatic model_victim(input logic [TW-1:0] tree, input logic [NW-1:0] lk,
                                output int way, output logic [TW-1:0] next);
        int   node;
        int   lo;
        int   half;
        logic take_lower;
        next = tree;
        node = 0;
        lo   = 0;
        way  = -1;
        if (lk != '1) begin
            for (int span = NW; span > 1; span = span / 2) begin
                half       = span / 2;
                take_lower = !tree[node];
                if (take_lower && !has_free(lk, lo, half)) begin
                    take_lower = 1'b0;
                end else if (!take_lower && !has_free(lk, lo + half, half)) begin
                    take_lower = 1'b1;
                end
                next[node] = take_lower;
                if (take_lower) begin
                    node = node + half;
                end else begin
                    node = node + 1;
                    lo   = lo + half;
                end
            end
            way = lo;
        end
    endtask

    // Every node on the path points at the half holding the hit way
    task automatic model_hit(input logic [TW-1:0] tree, input int way,
                             output logic [TW-1:0] next);
        int node;
        int lo;
        next = tree;
        node = 0;
        lo   = 0;
        for (int span = NW; span > 1; span = span / 2) begin
            if (way >= lo + span / 2) begin
                next[node] = 1'b0;
                node       = node + 1;
                lo         = lo + span / 2;
            end else begin
                next[node] = 1'b1;
                node       = node + span / 2;
            end
        end
    endtask

    task automatic add_row(input logic op, input int line, input logic [NW-1:0] mask,
                           input logic [NW-1:0] dirty_mask);
        op_tab[n_rows]    = op;
        line_tab[n_rows]  = IW'(line);
        mask_tab[n_rows]  = mask;
        dirty_tab[n_rows] = dirty_mask;
        n_rows = n_rows + 1;
    endtask

    task automatic add_random_evict(input int line);
        logic [31:0] lock_rnd;
        logic [31:0] dirty_rnd;
        lock_rnd  = $random(seed);
        dirty_rnd = $random(seed);
        add_row(ROW_EVICT, line, lock_rnd[NW-1:0], dirty_rnd[NW-1:0]);
    endtask

    task automatic build_table();
        n_rows = 0;
        // Fresh line walks through every way
        for (int i = 0; i < NW; i++) begin
            add_row(ROW_EVICT, 5, '0, i[0] ? ODD_WAYS : ~ODD_WAYS);
        end
        add_row(ROW_HIT, 5, WAY_ONE << (3 % NW), '0);
        add_row(ROW_EVICT, 5, '0, '0);
        add_row(ROW_HIT, 12, WAY_ONE, '0);
        add_row(ROW_EVICT, 12, '0, '1);
        add_row(ROW_HIT, 12, WAY_ONE << (6 % NW), '0);
        add_row(ROW_EVICT, 12, '0, '0);
        // Whole halves locked, then the full set
        add_row(ROW_EVICT, LINES - 1, LOW_HALF, UP_HALF);
        add_row(ROW_EVICT, LINES - 1, UP_HALF, LOW_HALF);
        add_row(ROW_EVICT, LINES - 1, '1, '1);
        add_row(ROW_EVICT, LINES - 1, '0, '0);
        add_row(ROW_EVICT, 5, '0, ODD_WAYS);
        for (int i = 0; i < 10; i++) begin
            add_random_evict(i[0] ? 12 : 0);
        end
        add_row(ROW_HIT, 0, WAY_ONE << (7 % NW), '0);
        add_row(ROW_HIT, 0, WAY_ONE << (2 % NW), '0);
        add_row(ROW_HIT, 0, WAY_ONE << (5 % NW), '0);
        add_random_evict(0);
        add_row(ROW_EVICT, 0, ~(WAY_ONE << (6 % NW)), ODD_WAYS);
        add_row(ROW_HIT, LINES - 1, WAY_ONE << 1, '0);
        add_row(ROW_EVICT, LINES - 1, '0, '1);
        for (int i = 0; i < 4; i++) begin
            add_random_evict(i[0] ? 12 : 5);
        end
    endtask

    task automatic predict_all();
        logic [TW-1:0] next;
        int            way;
        for (int l = 0; l < LINES; l++) begin
            model_mem[l] = '0;
        end
        for (int r = 0; r < ROWS; r++) begin
            exp_way_tab[r]   = -1;
            exp_dirty_tab[r] = 1'b0;
            if (op_tab[r] == ROW_HIT) begin
                model_hit(model_mem[line_tab[r]], way_index(mask_tab[r]), next);
            end else begin
                model_victim(model_mem[line_tab[r]], mask_tab[r], way, next);
                exp_way_tab[r] = way;
                if (way >= 0) begin
                    exp_dirty_tab[r] = dirty_tab[r][way];
                end
            end
            model_mem[line_tab[r]] = next;
        end
    endtask

    task automatic apply_row(input int r);
        int            cycles;
        logic [NW-1:0] exp_mask;
        exp_mask = (exp_way_tab[r] < 0) ? '0 : (WAY_ONE << exp_way_tab[r]);
        line_idx = line_tab[r];
        dirty    = dirty_tab[r];
        hit_way  = (op_tab[r] == ROW_HIT) ? mask_tab[r] : '0;
        lock     = (op_tab[r] == ROW_HIT) ? '0 : mask_tab[r];
        hit      = (op_tab[r] == ROW_HIT);
        evict    = (op_tab[r] == ROW_EVICT);
        @(negedge clk);
        hit    = 1'b0;
        evict  = 1'b0;
        cycles = 0;
        while (!hit_done && !victim_valid && cycles < DONE_LIMIT) begin
            checks++;
            if (!busy) begin
                errors++;
                $display("Row %0d: busy_o dropped while the operation was in flight", r);
            end
            @(negedge clk);
            cycles++;
        end
        checks++;
        if (cycles != 2 || busy) begin
            errors++;
            $display("Row %0d: done pulse not seen exactly 2 cycles after acceptance", r);
        end
        if (op_tab[r] == ROW_HIT) begin
            checks++;
            if (victim_valid !== 1'b0) begin
                errors++;
                $display("FAILED row %0d victim_valid_o got %h expected 0", r, victim_valid);
            end
            recent_hit[line_tab[r]] = way_index(mask_tab[r]);
        end else begin
            checks += 4;
            if (hit_done !== 1'b0) begin
                errors++;
                $display("FAILED row %0d hit_done_o got %h expected 0", r, hit_done);
            end
            if (victim_way !== exp_mask) begin
                errors++;
                $display("FAILED row %0d victim_way_o got %h expected %h", r, victim_way,
                         exp_mask);
            end
            if (evict_dirty !== exp_dirty_tab[r]) begin
                errors++;
                $display("FAILED row %0d evict_dirty_o got %h expected %h", r, evict_dirty,
                         exp_dirty_tab[r]);
            end
            if ((victim_way & mask_tab[r]) != '0) begin
                errors++;
                $display("Row %0d: the victim is a locked way", r);
            end
            if (mask_tab[r] == '0 && recent_hit[line_tab[r]] >= 0) begin
                checks++;
                if (victim_way[recent_hit[line_tab[r]]]) begin
                    errors++;
                    $display("Row %0d: the victim is the way hit just before", r);
                end
            end
            recent_hit[line_tab[r]] = -1;
            if (r == 0 && victim_way !== WAY_ONE) begin
                errors++;
                $display("FAILED row 0 victim_way_o got %h expected %h", victim_way, WAY_ONE);
            end
            if (r < NW) begin
                seen_first = seen_first | victim_way;
            end
        end
        @(negedge clk);
        checks++;
        if (hit_done || victim_valid) begin
            errors++;
            $display("Row %0d: done pulse lasted longer than one cycle", r);
        end
    endtask

    initial begin
        seed       = 87529;
        errors     = 0;
        checks     = 0;
        seen_first = '0;
        rst_n      = 1'b0;
        hit        = 1'b0;
        evict      = 1'b0;
        hit_way    = '0;
        line_idx   = '0;
        lock       = '0;
        dirty      = '0;
        for (int l = 0; l < LINES; l++) begin
            recent_hit[l] = -1;
        end
        build_table();
        predict_all();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        checks++;
        if (busy || hit_done || victim_valid || evict_dirty || victim_way != '0) begin
            errors++;
            $display("FAILED after reset busy_o %h hit_done_o %h victim_valid_o %h",
                     busy, hit_done, victim_valid);
            $display("FAILED after reset evict_dirty_o %h victim_way_o %h",
                     evict_dirty, victim_way);
        end

        for (int r = 0; r < ROWS; r++) begin
            apply_row(r);
        end
        checks++;
        if (seen_first !== '1) begin
            errors++;
            $display("The first %0d evictions on a fresh line missed some ways", NW);
        end

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- source/plru_top.sv
////////////////////////////////////////
// PLRU replacement policy top level
// Controller, record storage and tree
// update logic
////////////////////////////////////////

`timescale 1ns/1ps

module plru_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     hit_i,
    input  logic                     evict_i,
    input  plru_tree_pkg::way_t      hit_way_i,
    input  plru_tree_pkg::line_idx_t line_idx_i,
    input  plru_tree_pkg::way_t      lock_i,
    input  plru_tree_pkg::way_t      dirty_i,
    output logic                     busy_o,
    output logic                     hit_done_o,
    output logic                     victim_valid_o,
    output plru_tree_pkg::way_t      victim_way_o,
    output logic                     evict_dirty_o
);

    logic                     ram_req;
    logic                     ram_we;
    plru_tree_pkg::line_idx_t ram_addr;
    plru_tree_pkg::tree_t     ram_wdata;
    plru_tree_pkg::tree_t     ram_rdata;
    plru_tree_pkg::tree_t     hit_tree;
    plru_tree_pkg::tree_t     victim_tree;
    plru_tree_pkg::way_t      victim_way;

    plru_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .hit_i          (hit_i),
        .evict_i        (evict_i),
        .line_idx_i     (line_idx_i),
        .dirty_i        (dirty_i),
        .ram_req_o      (ram_req),
        .ram_we_o       (ram_we),
        .ram_addr_o     (ram_addr),
        .ram_wdata_o    (ram_wdata),
        .hit_tree_i     (hit_tree),
        .victim_tree_i  (victim_tree),
        .victim_way_i   (victim_way),
        .busy_o         (busy_o),
        .hit_done_o     (hit_done_o),
        .victim_valid_o (victim_valid_o),
        .evict_dirty_o  (evict_dirty_o),
        .victim_way_o   (victim_way_o)
    );

    plru_bit_ram u_ram (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (ram_req),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    // Both tree units work on the record just read
    plru_hit_update u_hit_update (
        .tree_i    (ram_rdata),
        .hit_way_i (hit_way_i),
        .tree_o    (hit_tree)
    );

    plru_victim_select u_victim_select (
        .tree_i       (ram_rdata),
        .lock_i       (lock_i),
        .victim_way_o (victim_way),
        .tree_o       (victim_tree)
    );

endmodule

//--- source/plru_ctrl.sv
////////////////////////////////////////
// PLRU controller
// Sequences record read, update and
// write-back for hits and evictions
////////////////////////////////////////

`timescale 1ns/1ps

`include "plru_defs.svh"

module plru_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     hit_i,
    input  logic                     evict_i,
    input  plru_tree_pkg::line_idx_t line_idx_i,
    input  plru_tree_pkg::way_t      dirty_i,
    output logic                     ram_req_o,
    output logic                     ram_we_o,
    output plru_tree_pkg::line_idx_t ram_addr_o,
    output plru_tree_pkg::tree_t     ram_wdata_o,
    input  plru_tree_pkg::tree_t     hit_tree_i,
    input  plru_tree_pkg::tree_t     victim_tree_i,
    input  plru_tree_pkg::way_t      victim_way_i,
    output logic                     busy_o,
    output logic                     hit_done_o,
    output logic                     victim_valid_o,
    output logic                     evict_dirty_o,
    output plru_tree_pkg::way_t      victim_way_o
);

    plru_ctrl_pkg::ctrl_state_t state_q;
    plru_ctrl_pkg::ctrl_state_t state_d;
    plru_ctrl_pkg::op_t         op_q;
    logic                       accept;
    logic                       finish;
    logic                       evict_done;

    // Pulses only count while idle
    assign accept     = (state_q == plru_ctrl_pkg::IDLE) && (hit_i || evict_i);
    assign finish     = (state_q == plru_ctrl_pkg::UPDATE);
    assign evict_done = finish && (op_q == plru_ctrl_pkg::OP_EVICT);

    always_comb begin
        state_d = state_q;
        case (state_q)
            plru_ctrl_pkg::IDLE: begin
                if (accept) begin
                    state_d = plru_ctrl_pkg::READ;
                end
            end
            plru_ctrl_pkg::READ: begin
                state_d = plru_ctrl_pkg::UPDATE;
            end
            plru_ctrl_pkg::UPDATE: begin
                state_d = plru_ctrl_pkg::IDLE;
            end
            default: begin
                state_d = plru_ctrl_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= plru_ctrl_pkg::IDLE;
            op_q    <= plru_ctrl_pkg::OP_HIT;
        end else begin
            state_q <= state_d;
            if (accept) begin
                op_q <= hit_i ? plru_ctrl_pkg::OP_HIT : plru_ctrl_pkg::OP_EVICT;
            end
        end
    end

    // Read in READ, write back in UPDATE
    // Caller holds the line index until done
    assign ram_req_o   = (state_q == plru_ctrl_pkg::READ) || finish;
    assign ram_we_o    = finish;
    assign ram_addr_o  = line_idx_i;
    assign ram_wdata_o = (op_q == plru_ctrl_pkg::OP_HIT) ? hit_tree_i : victim_tree_i;

    assign busy_o = (state_q != plru_ctrl_pkg::IDLE);

    // Done outputs register at the write-back edge
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hit_done_o     <= 1'b0;
            victim_valid_o <= 1'b0;
            evict_dirty_o  <= 1'b0;
            victim_way_o   <= '0;
        end else begin
            hit_done_o     <= finish && (op_q == plru_ctrl_pkg::OP_HIT);
            victim_valid_o <= evict_done;
            evict_dirty_o  <= evict_done && |(victim_way_i & dirty_i);
            victim_way_o   <= evict_done ? victim_way_i : '0;
        end
    end

    hit_evict_excl_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(hit_i && evict_i)
    ) else $error("hit and evict pulsed together");

endmodule

//--- source/plru_victim_select.sv
////////////////////////////////////////
// PLRU victim selection
// Walks the tree away from recent use
// and around scratchpad-locked ways
////////////////////////////////////////

`timescale 1ns/1ps

`include "plru_defs.svh"

module plru_victim_select (
    input  plru_tree_pkg::tree_t tree_i,
    input  plru_tree_pkg::way_t  lock_i,
    output plru_tree_pkg::way_t  victim_way_o,
    output plru_tree_pkg::tree_t tree_o
);

    localparam int LEVELS = $clog2(`PLRU_NUM_WAYS);
    localparam plru_tree_pkg::way_t WAY_ONE = 1;

    always_comb begin
        plru_tree_pkg::tree_t tree_d;
        plru_tree_pkg::way_t  lower_m;
        plru_tree_pkg::way_t  upper_m;
        int                   node;
        int                   base;
        int                   span;
        logic                 go_lower;

        tree_d = tree_i;
        node   = 0;
        base   = 0;
        span   = `PLRU_NUM_WAYS;

        for (int lvl = 0; lvl < LEVELS; lvl++) begin
            lower_m = ((WAY_ONE << (span / 2)) - WAY_ONE) << base;
            upper_m = lower_m << (span / 2);

            // Head for the half not used last
            go_lower = !tree_i[node];

            // A half with every way locked cannot give the victim
            if (go_lower && ((lower_m & ~lock_i) == '0)) begin
                go_lower = 1'b0;
            end else if (!go_lower && ((upper_m & ~lock_i) == '0)) begin
                go_lower = 1'b1;
            end

            // Node now points at the half just taken
            tree_d[node] = go_lower;

            if (go_lower) begin
                node = node + span / 2;
            end else begin
                node = node + 1;
                base = base + span / 2;
            end
            span = span / 2;
        end

        // Nothing to evict when the whole set is scratchpad
        if (&lock_i) begin
            victim_way_o = '0;
            tree_o       = tree_i;
        end else begin
            victim_way_o = WAY_ONE << base;
            tree_o       = tree_d;
        end
    end

endmodule

//--- source/plru_hit_update.sv
////////////////////////////////////////
// PLRU hit update
// Marks the path to the hit way as most
// recently used
////////////////////////////////////////

`timescale 1ns/1ps

`include "plru_defs.svh"

module plru_hit_update (
    input  plru_tree_pkg::tree_t tree_i,
    input  plru_tree_pkg::way_t  hit_way_i,
    output plru_tree_pkg::tree_t tree_o
);

    localparam int LEVELS = $clog2(`PLRU_NUM_WAYS);
    localparam plru_tree_pkg::way_t WAY_ONE = 1;

    always_comb begin
        plru_tree_pkg::tree_t tree_d;
        plru_tree_pkg::way_t  lower_m;
        plru_tree_pkg::way_t  upper_m;
        int                   node;
        int                   base;
        int                   span;
        logic                 in_upper;
        logic                 in_lower;

        tree_d = tree_i;
        node   = 0;
        base   = 0;
        span   = `PLRU_NUM_WAYS;

        for (int lvl = 0; lvl < LEVELS; lvl++) begin
            // Ways covered by the two halves below this node
            lower_m = ((WAY_ONE << (span / 2)) - WAY_ONE) << base;
            upper_m = lower_m << (span / 2);

            in_upper = |(hit_way_i & upper_m);
            in_lower = |(hit_way_i & lower_m);

            if (in_upper) begin
                tree_d[node] = 1'b0;
                // Upper subtree sits right after its parent
                node = node + 1;
                base = base + span / 2;
            end else begin
                if (in_lower) begin
                    tree_d[node] = 1'b1;
                end
                // Skip over the upper subtree
                node = node + span / 2;
            end
            span = span / 2;
        end

        tree_o = tree_d;
    end

    // Zero is normal while no hit is in flight
    always_comb begin
        if (!$isunknown(hit_way_i)) begin
            hit_onehot_a: assert ($onehot0(hit_way_i))
                else $error("hit way %b is not one-hot", hit_way_i);
        end
    end

endmodule

//--- source/plru_bit_ram.sv
////////////////////////////////////////
// PLRU record storage
// Single-port register array with a
// registered read port
////////////////////////////////////////

`timescale 1ns/1ps

`include "plru_defs.svh"

module plru_bit_ram (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     req_i,
    input  logic                     we_i,
    input  plru_tree_pkg::line_idx_t addr_i,
    input  plru_tree_pkg::tree_t     wdata_i,
    output plru_tree_pkg::tree_t     rdata_o
);

    plru_tree_pkg::tree_t mem_q [`PLRU_NUM_LINES];

    // All records start at zero
    // so the first victim of every line is way 0
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `PLRU_NUM_LINES; i++) begin
                mem_q[i] <= '0;
            end
        end else if (req_i && we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
    end

    // Read data appears one cycle after the request
    always_ff @(posedge clk_i) begin
        if (req_i && !we_i) begin
            rdata_o <= mem_q[addr_i];
        end
    end

    // Index width may exceed the line count for other configurations
    addr_in_range_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        req_i |-> (int'(addr_i) < `PLRU_NUM_LINES)
    ) else $error("record address %0d beyond line count", addr_i);

endmodule

//--- source/plru_ctrl_pkg.sv
////////////////////////////////////////
// PLRU controller types
// Sequencer states and operation kinds
////////////////////////////////////////

package plru_ctrl_pkg;

    // Read the record, then update and write it back
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        READ   = 2'd1,
        UPDATE = 2'd2
    } ctrl_state_t;

    // Operation in flight
    typedef enum logic {
        OP_HIT   = 1'b0,
        OP_EVICT = 1'b1
    } op_t;

endpackage

//--- source/plru_tree_pkg.sv
////////////////////////////////////////
// Tree PLRU data types
// Way masks, per-line tree records and
// line indices
////////////////////////////////////////

`include "plru_defs.svh"

package plru_tree_pkg;

    // One bit per way
    // One-hot when it names a way
    // Used as a mask for locks and dirty flags
    typedef logic [`PLRU_NUM_WAYS-1:0] way_t;

    // Tree record of one cache line, stored in preorder
    // Root at bit 0, then the upper-half subtree, then the lower-half subtree
    // A node at 0 marks the upper half as last used
    // A node at 1 marks the lower half as last used
    typedef logic [`PLRU_TREE_W-1:0] tree_t;

    // Cache line address into the record storage
    typedef logic [`PLRU_INDEX_W-1:0] line_idx_t;

endpackage

//--- source/plru_defs.svh
////////////////////////////////////////
// PLRU configuration
// Associativity, line count and the
// widths derived from them
////////////////////////////////////////

`ifndef PLRU_DEFS_SVH
`define PLRU_DEFS_SVH

// Associativity as a power of two from 2 to 32
`define PLRU_NUM_WAYS 8

// Cache lines tracked with one tree record each
`define PLRU_NUM_LINES 64

// log2 of the line count
`define PLRU_INDEX_W 6

// A binary tree over N ways has N-1 nodes
`define PLRU_TREE_W (`PLRU_NUM_WAYS - 1)

// Record storage read latency in cycles
`define PLRU_READ_LAT 1

`define PLRU_WAYS_SUPPORTED ((`PLRU_NUM_WAYS == 2) || (`PLRU_NUM_WAYS == 4) || \
    (`PLRU_NUM_WAYS == 8) || (`PLRU_NUM_WAYS == 16) || (`PLRU_NUM_WAYS == 32))

// Two enum members with one value do not compile
// An unsupported way count collapses both members onto zero
typedef enum logic [1:0] {
    PLRU_WAYS_BASE = 2'd0,
    PLRU_WAYS_OK   = `PLRU_WAYS_SUPPORTED ? 2'd1 : 2'd0
} plru_ways_check_e;

`endif
